//--- include/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// --------------------------------------------------
// address spaces, reg_addr[15:12]
// --------------------------------------------------
`define ADDR_MAIN       4'h0            // board registers
`define ADDR_EXT        4'h6            // served by the external read port only

// main-space register offsets, reg_addr[3:0]
`define REG_STATUS      4'd0            // board id and watchdog status
`define REG_PHYCTRL     4'd1            // write starts a phy link request
`define REG_WDOG        4'd3            // watchdog period
`define REG_VERSION     4'd4            // firmware version
`define REG_SCRATCH     4'd5            // free read/write quadlet

// --------------------------------------------------
// phy link request
// --------------------------------------------------
`define LREQ_REG_RD     3'd1            // phy register read
`define LREQ_REG_WR     3'd5            // phy register write
`define LREQ_FRAME_BITS 16              // start bit + 3 type bits + 12 payload bits

// misc constants
`define FW_VERSION      32'h0000_0008   // returned by REG_VERSION
`define WDOG_PRESCALE   4               // sysclk cycles per watchdog tick

`endif

//--- hw/bus_pkg.sv
package bus_pkg;

    // --------------------------------------------------
    // register bus
    // --------------------------------------------------
    typedef logic [15:0] reg_addr_t;    // [15:12] space, [3:0] main-space register
    typedef logic [31:0] reg_data_t;    // one quadlet
    typedef logic [3:0]  board_id_t;    // rotary switch value

    // --------------------------------------------------
    // phy link request
    // --------------------------------------------------
    typedef logic [2:0]  lreq_type_t;   // request type, sent msb first
    typedef logic [11:0] phy_data_t;    // {phy reg[3:0], data[7:0]}

    // serializer states
    typedef enum logic [1:0]
    {
        IDLE,   // lreq low, waiting for a trigger
        SHIFT,  // frame bits on lreq
        STOP    // single low cycle closing the frame
    } lreq_state_e;

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    typedef logic [15:0] wdog_count_t;  // period and down counter

endpackage

//--- hw/bus_arbiter.sv
module bus_arbiter
(
    input  logic               sysclk,
    input  logic               reset,

    // fw host
    input  logic               fw_req_read,
    input  bus_pkg::reg_addr_t fw_raddr,
    input  logic               fw_req_write,
    input  logic               fw_wen,
    input  bus_pkg::reg_addr_t fw_waddr,
    input  bus_pkg::reg_data_t fw_wdata,
    input  logic               fw_blk_wen,
    input  logic               fw_blk_wstart,

    // eth host
    input  logic               eth_req_read,
    input  bus_pkg::reg_addr_t eth_raddr,
    input  logic               eth_req_write,
    input  logic               eth_wen,
    input  bus_pkg::reg_addr_t eth_waddr,
    input  bus_pkg::reg_data_t eth_wdata,
    input  logic               eth_blk_wen,
    input  logic               eth_blk_wstart,

    // grants back to the hosts
    output logic               fw_grant_read,
    output logic               eth_grant_read,
    output logic               fw_grant_write,
    output logic               eth_grant_write,

    // shared bus
    output bus_pkg::reg_addr_t reg_raddr,
    output logic               reg_wen,
    output bus_pkg::reg_addr_t reg_waddr,
    output bus_pkg::reg_data_t reg_wdata,
    output logic               blk_wen,
    output logic               blk_wstart
);

    // --------------------------------------------------
    // grants, fw wins and also owns an idle bus
    // --------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            fw_grant_read   <= 1'b1;                            // fw owns both buses
            eth_grant_read  <= 1'b0;
            fw_grant_write  <= 1'b1;
            eth_grant_write <= 1'b0;
        end
        else
        begin
            fw_grant_read   <= fw_req_read | ~eth_req_read;
            eth_grant_read  <= ~fw_req_read & eth_req_read;
            fw_grant_write  <= fw_req_write | ~eth_req_write;
            eth_grant_write <= ~fw_req_write & eth_req_write;
        end
    end

    // read side, only the address moves
    assign reg_raddr = eth_grant_read ? eth_raddr : fw_raddr;

    // write side follows the write grant
    always_comb
    begin
        if (eth_grant_write)
        begin
            reg_wen    = eth_wen;
            reg_waddr  = eth_waddr;
            reg_wdata  = eth_wdata;
            blk_wen    = eth_blk_wen;
            blk_wstart = eth_blk_wstart;
        end
        else
        begin
            reg_wen    = fw_wen;
            reg_waddr  = fw_waddr;
            reg_wdata  = fw_wdata;
            blk_wen    = fw_blk_wen;
            blk_wstart = fw_blk_wstart;
        end
    end

endmodule

//--- hw/read_data_router.sv
`include "bus_macros.svh"

module read_data_router
(
    input  logic               sysclk,
    input  logic               reset,
    input  bus_pkg::reg_addr_t reg_raddr,
    input  bus_pkg::reg_data_t board_rdata,    // board register file
    input  bus_pkg::reg_data_t ext_rdata,      // external read port
    input  logic               ext_rwait,      // external data lags the address by one edge
    output bus_pkg::reg_data_t reg_rdata,
    output logic               reg_rvalid
);

    import bus_pkg::*;

    reg_addr_t raddr_q;         // address at the previous edge
    logic      raddr_q_vld;     // raddr_q has been loaded since reset
    logic      is_addr_main;
    logic      raddr_held;

    // --------------------------------------------------
    // read data
    // --------------------------------------------------
    // main space needs the register index to fit in [3:0]
    assign is_addr_main = (reg_raddr[15:12] == `ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    assign reg_rdata = is_addr_main ? (board_rdata | ext_rdata) : ext_rdata;

    // --------------------------------------------------
    // read valid
    // --------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        raddr_q <= reg_raddr;
        if (reset)
            raddr_q_vld <= 1'b0;
        else
            raddr_q_vld <= 1'b1;
    end

    assign raddr_held = raddr_q_vld && (raddr_q == reg_raddr);   // stable for one edge

    // no wait state -> same cycle, else once the address has settled
    assign reg_rvalid = ~ext_rwait | raddr_held;

endmodule

//--- hw/board_regs.sv
`include "bus_macros.svh"

module board_regs
(
    input  logic                sysclk,
    input  logic                reset,
    input  bus_pkg::board_id_t  board_id,
    input  bus_pkg::reg_addr_t  reg_raddr,
    input  bus_pkg::reg_addr_t  reg_waddr,
    input  bus_pkg::reg_data_t  reg_wdata,
    input  logic                reg_wen,
    input  logic                wdog_clear,
    output bus_pkg::reg_data_t  board_rdata,
    output logic                lreq_trig,
    output bus_pkg::lreq_type_t lreq_type,
    output bus_pkg::phy_data_t  lreq_data,
    output logic                wdog_period_led,
    output logic [2:0]          wdog_period_status,
    output logic                wdog_timeout
);

    import bus_pkg::*;

    reg_data_t   scratch;
    wdog_count_t wdog_period;   // in ticks of WDOG_PRESCALE cycles, 0 -> disabled
    wdog_count_t wdog_count;    // cycles left before timeout
    wdog_count_t wdog_reload;
    logic        wr_main;
    logic        wr_wdog;
    logic        wr_scratch;
    logic        wdog_expire;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------
    assign wr_main    = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign wr_wdog    = wr_main && (reg_waddr[3:0] == `REG_WDOG);
    assign wr_scratch = wr_main && (reg_waddr[3:0] == `REG_SCRATCH);

    // phy control write goes straight to the serializer
    assign lreq_trig = wr_main && (reg_waddr[3:0] == `REG_PHYCTRL);
    assign lreq_type = reg_wdata[12] ? `LREQ_REG_WR : `LREQ_REG_RD;
    assign lreq_data = reg_wdata[11:0];   // phy reg number + data byte

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            scratch     <= '0;
            wdog_period <= '0;
        end
        else
        begin
            if (wr_scratch)
                scratch <= reg_wdata;
            if (wr_wdog)
                wdog_period <= reg_wdata[15:0];
        end
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    // a period write counts from the new value
    assign wdog_reload = wdog_count_t'((wr_wdog ? reg_wdata[15:0] : wdog_period) * `WDOG_PRESCALE);

    // last decrement, 1 -> 0
    assign wdog_expire = (wdog_period != '0) && (wdog_count == wdog_count_t'(1)) && !wr_main;

    always_ff @(posedge sysclk)
    begin
        if (reset)
            wdog_count <= '0;
        else if (wr_main)
            wdog_count <= wdog_reload;              // any host activity restarts it
        else if ((wdog_period != '0) && (wdog_count != '0))
            wdog_count <= wdog_count - 1'b1;
    end

    always_ff @(posedge sysclk)
    begin
        if (reset)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || wr_wdog)
            wdog_timeout <= 1'b0;
        else if (wdog_expire)
            wdog_timeout <= 1'b1;                   // sticky until cleared
    end

    assign wdog_period_led    = (wdog_period != '0);
    assign wdog_period_status = wdog_period_led ? ({1'b0, wdog_period[15:14]} + 3'd1) : 3'd0;

    // --------------------------------------------------
    // read mux, main-space check is done by the router
    // --------------------------------------------------
    always_comb
    begin
        case (reg_raddr[3:0])
            `REG_STATUS:  board_rdata = {4'd0, board_id, 20'd0, wdog_period_status, wdog_timeout};
            `REG_WDOG:    board_rdata = {16'd0, wdog_period};
            `REG_VERSION: board_rdata = `FW_VERSION;
            `REG_SCRATCH: board_rdata = scratch;
            default:      board_rdata = '0;
        endcase
    end

endmodule

//--- hw/phy_request.sv
`include "bus_macros.svh"

module phy_request
(
    input  logic                sysclk,
    input  logic                reset,
    input  logic                lreq_trig,
    input  bus_pkg::lreq_type_t lreq_type,
    input  bus_pkg::phy_data_t  lreq_data,
    output logic                lreq        // serial link request to the phy
);

    import bus_pkg::*;

    localparam int CNT_W = $clog2(`LREQ_FRAME_BITS);

    lreq_state_e                 state;
    logic [`LREQ_FRAME_BITS-1:0] frame;     // msb is the bit on lreq
    logic [CNT_W-1:0]            bit_cnt;   // frame bits already sent

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            state   <= IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (lreq_trig)
                    begin
                        state   <= SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SHIFT:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(`LREQ_FRAME_BITS - 1))
                        state <= STOP;              // last frame bit is out
                end
                STOP:    state <= IDLE;             // one low cycle
                default: state <= IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // shift register
    // --------------------------------------------------
    // a trigger outside IDLE never loads, so it is dropped
    always_ff @(posedge sysclk)
    begin
        if ((state == IDLE) && lreq_trig)
            frame <= {1'b1, lreq_type, lreq_data};                  // start, type, payload
        else if (state == SHIFT)
            frame <= {frame[`LREQ_FRAME_BITS-2:0], 1'b0};
    end

    assign lreq = (state == SHIFT) && frame[`LREQ_FRAME_BITS-1];

endmodule

//--- hw/board_bus_core.sv
module board_bus_core
(
    input  logic                sysclk,
    input  logic                reset,

    // fw host
    input  logic                fw_req_read,
    input  bus_pkg::reg_addr_t  fw_raddr,
    input  logic                fw_req_write,
    input  logic                fw_wen,
    input  bus_pkg::reg_addr_t  fw_waddr,
    input  bus_pkg::reg_data_t  fw_wdata,
    input  logic                fw_blk_wen,
    input  logic                fw_blk_wstart,
    output logic                fw_grant_read,
    output logic                fw_grant_write,

    // eth host
    input  logic                eth_req_read,
    input  bus_pkg::reg_addr_t  eth_raddr,
    input  logic                eth_req_write,
    input  logic                eth_wen,
    input  bus_pkg::reg_addr_t  eth_waddr,
    input  bus_pkg::reg_data_t  eth_wdata,
    input  logic                eth_blk_wen,
    input  logic                eth_blk_wstart,
    output logic                eth_grant_read,
    output logic                eth_grant_write,

    // shared bus, also seen by the external board
    output bus_pkg::reg_addr_t  reg_raddr,
    output bus_pkg::reg_data_t  reg_rdata,
    output logic                reg_rvalid,
    output logic                reg_wen,
    output bus_pkg::reg_addr_t  reg_waddr,
    output bus_pkg::reg_data_t  reg_wdata,
    output logic                blk_wen,
    output logic                blk_wstart,
    input  bus_pkg::reg_data_t  ext_rdata,
    input  logic                ext_rwait,

    // board
    input  bus_pkg::board_id_t  board_id,
    input  logic                wdog_clear,
    output logic                wdog_period_led,
    output logic [2:0]          wdog_period_status,
    output logic                wdog_timeout,
    output logic                lreq
);

    import bus_pkg::*;

    reg_data_t  board_rdata;    // board register read value
    logic       lreq_trig;      // phy control register written
    lreq_type_t lreq_type;
    phy_data_t  lreq_data;

    // --------------------------------------------------
    // arbitration
    // --------------------------------------------------
    bus_arbiter i_bus_arbiter
    (
        .sysclk          (sysclk),
        .reset           (reset),
        .fw_req_read     (fw_req_read),
        .fw_raddr        (fw_raddr),
        .fw_req_write    (fw_req_write),
        .fw_wen          (fw_wen),
        .fw_waddr        (fw_waddr),
        .fw_wdata        (fw_wdata),
        .fw_blk_wen      (fw_blk_wen),
        .fw_blk_wstart   (fw_blk_wstart),
        .eth_req_read    (eth_req_read),
        .eth_raddr       (eth_raddr),
        .eth_req_write   (eth_req_write),
        .eth_wen         (eth_wen),
        .eth_waddr       (eth_waddr),
        .eth_wdata       (eth_wdata),
        .eth_blk_wen     (eth_blk_wen),
        .eth_blk_wstart  (eth_blk_wstart),
        .fw_grant_read   (fw_grant_read),
        .eth_grant_read  (eth_grant_read),
        .fw_grant_write  (fw_grant_write),
        .eth_grant_write (eth_grant_write),
        .reg_raddr       (reg_raddr),
        .reg_wen         (reg_wen),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .blk_wen         (blk_wen),
        .blk_wstart      (blk_wstart)
    );

    read_data_router i_read_data_router
    (
        .sysclk      (sysclk),
        .reset       (reset),
        .reg_raddr   (reg_raddr),
        .board_rdata (board_rdata),
        .ext_rdata   (ext_rdata),
        .ext_rwait   (ext_rwait),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid)
    );

    // --------------------------------------------------
    // board registers and phy request
    // --------------------------------------------------
    board_regs i_board_regs
    (
        .sysclk             (sysclk),
        .reset              (reset),
        .board_id           (board_id),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .wdog_clear         (wdog_clear),
        .board_rdata        (board_rdata),
        .lreq_trig          (lreq_trig),
        .lreq_type          (lreq_type),
        .lreq_data          (lreq_data),
        .wdog_period_led    (wdog_period_led),
        .wdog_period_status (wdog_period_status),
        .wdog_timeout       (wdog_timeout)
    );

    phy_request i_phy_request
    (
        .sysclk    (sysclk),
        .reset     (reset),
        .lreq_trig (lreq_trig),
        .lreq_type (lreq_type),
        .lreq_data (lreq_data),
        .lreq      (lreq)
    );

endmodule

//--- dv/board_bus_core_assert.sv
module board_bus_core_assert
#(
    parameter bit ARB_SIDE = 1'b1   // 1 -> grant checks, 0 -> serializer check
)
(
    input logic                 sysclk,
    input logic                 reset,
    input logic                 fw_req_read,
    input logic                 eth_req_read,
    input logic                 fw_grant_read,
    input logic                 eth_grant_read,
    input logic                 fw_grant_write,
    input logic                 eth_grant_write,
    input bus_pkg::lreq_state_e state,
    input logic                 lreq
);

    import bus_pkg::*;

    if (ARB_SIDE)
    begin : g_arb
        // --------------------------------------------------
        // arbiter
        // --------------------------------------------------
        a_read_onehot: assert property (@(posedge sysclk) disable iff (reset)
            fw_grant_read ^ eth_grant_read)
            else $error("read grants are not one-hot");

        a_write_onehot: assert property (@(posedge sysclk) disable iff (reset)
            fw_grant_write ^ eth_grant_write)
            else $error("write grants are not one-hot");

        // grant flop follows the request sampled one edge earlier
        a_grant_timing: assert property (@(posedge sysclk) disable iff (reset)
            $changed(fw_grant_read) |->
                ($past({fw_req_read, eth_req_read}, 1) != $past({fw_req_read, eth_req_read}, 2)))
            else $error("read grant changed without a request change one cycle before");
    end
    else
    begin : g_phy
        // --------------------------------------------------
        // serializer
        // --------------------------------------------------
        a_lreq_idle: assert property (@(posedge sysclk) disable iff (reset)
            (state == IDLE) |-> !lreq)
            else $error("lreq is high while the serializer is idle");
    end

endmodule

// unused side of each binding is tied to a legal constant
bind bus_arbiter board_bus_core_assert #(.ARB_SIDE (1'b1)) i_arb_assert
(
    .sysclk, .reset, .fw_req_read, .eth_req_read,
    .fw_grant_read, .eth_grant_read, .fw_grant_write, .eth_grant_write,
    .state (bus_pkg::IDLE),
    .lreq  (1'b0)
);

bind phy_request board_bus_core_assert #(.ARB_SIDE (1'b0)) i_phy_assert
(
    .sysclk, .reset,
    .fw_req_read (1'b1), .eth_req_read (1'b0),
    .fw_grant_read (1'b1), .eth_grant_read (1'b0),
    .fw_grant_write (1'b1), .eth_grant_write (1'b0),
    .state, .lreq
);

//--- dv/board_bus_core_tb.sv
`include "bus_macros.svh"

module board_bus_core_tb;

    import bus_pkg::*;

    localparam int CYCLE_LIMIT = 4000;  // whole run is a few hundred cycles
    localparam int SEL_RDATA = 0, SEL_GRANT = 1, SEL_LREQ = 2, SEL_RVALID = 3;
    localparam int SEL_TMO = 4, SEL_WDSTAT = 5, SEL_WADDR = 6;
    localparam int SEL_RADDR = 7, SEL_WDATA = 8, SEL_WCTRL = 9;

    logic sysclk = 1'b0, reset;
    logic fw_req_read, fw_req_write, fw_wen, fw_blk_wen, fw_blk_wstart;
    logic eth_req_read, eth_req_write, eth_wen, eth_blk_wen, eth_blk_wstart;
    reg_addr_t fw_raddr, fw_waddr, eth_raddr, eth_waddr, reg_raddr, reg_waddr;
    reg_data_t fw_wdata, eth_wdata, reg_rdata, reg_wdata, ext_rdata;
    logic fw_grant_read, fw_grant_write, eth_grant_read, eth_grant_write;
    logic reg_rvalid, reg_wen, blk_wen, blk_wstart, ext_rwait, wdog_clear;
    logic wdog_period_led, wdog_timeout, lreq;
    logic [2:0] wdog_period_status;
    board_id_t board_id;

    reg_data_t   m_scratch;         // reference copies of the board registers
    wdog_count_t m_period;
    logic        m_timeout;
    int          cycle_cnt = 0;
    logic        chk_en = 1'b0;     // compare armed for the coming negedge
    int          chk_sel;
    string       chk_name;
    logic [31:0] chk_exp, actual_val, d;
    logic [15:0] frame_exp;         // expected lreq frame, msb first

    board_bus_core i_board_bus_core (.*);

    always #2 sysclk = ~sysclk;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic reg_data_t ref_read(input reg_addr_t a, input reg_data_t ext_v);
        reg_data_t  v;
        logic [2:0] stat;
        stat = (m_period == 0) ? 3'd0 : 3'({1'b0, m_period[15:14]} + 3'd1);
        case (a[3:0])
            `REG_STATUS:  v = {4'd0, board_id, 20'd0, stat, m_timeout};
            `REG_WDOG:    v = {16'd0, m_period};
            `REG_VERSION: v = `FW_VERSION;
            `REG_SCRATCH: v = m_scratch;
            default:      v = '0;
        endcase
        if ((a[15:12] == `ADDR_MAIN) && (a[7:4] == 4'd0))
            return v | ext_v;           // board file ORed onto the external port
        return ext_v;
    endfunction

    function automatic logic [1:0] ref_grants(input logic fw_req, input logic eth_req);
        return {fw_req | ~eth_req, ~fw_req & eth_req};     // {fw, eth}
    endfunction

    function automatic logic [15:0] ref_frame(input reg_data_t w);
        return {1'b1, (w[12] ? `LREQ_REG_WR : `LREQ_REG_RD), w[11:0]};
    endfunction

    // --------------------------------------------------
    // compare and timeout
    // --------------------------------------------------
    always_comb
    begin
        case (chk_sel)
            SEL_RDATA:  actual_val = reg_rdata;
            SEL_GRANT:  actual_val = {28'd0, fw_grant_read, eth_grant_read,
                                      fw_grant_write, eth_grant_write};
            SEL_LREQ:   actual_val = {31'd0, lreq};
            SEL_RVALID: actual_val = {31'd0, reg_rvalid};
            SEL_TMO:    actual_val = {31'd0, wdog_timeout};
            SEL_WDSTAT: actual_val = {28'd0, wdog_period_led, wdog_period_status};
            SEL_RADDR:  actual_val = {16'd0, reg_raddr};
            SEL_WDATA:  actual_val = reg_wdata;
            SEL_WCTRL:  actual_val = {29'd0, reg_wen, blk_wen, blk_wstart};
            default:    actual_val = {16'd0, reg_waddr};
        endcase
    end

    always @(negedge sysclk)        // mid-cycle, outputs settled
    begin
        if (chk_en)
            assert (actual_val === chk_exp)
            else
            begin
                $display("[ERROR] %s: expected %h, actual %h", chk_name, chk_exp, actual_val);
                $display("Finished with errors");
                $fatal(1, "output mismatch");
            end
    end

    always @(posedge sysclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // stimulus helpers, all in the posedge+1 phase
    // --------------------------------------------------
    task automatic tick(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    task automatic step_check(input string name, input int sel, input logic [31:0] exp);
        chk_name = name;
        chk_sel  = sel;
        chk_exp  = exp;
        chk_en   = 1'b1;
        tick(1);
        chk_en   = 1'b0;
    endtask

    task automatic set_requests(input logic fw, input logic eth);
        fw_req_read   = fw;
        fw_req_write  = fw;
        eth_req_read  = eth;
        eth_req_write = eth;
        tick(1);                    // grant is registered
    endtask

    task automatic write_reg(input bit use_eth, input logic [3:0] offs, input reg_data_t data);
        if (use_eth)
        begin
            eth_wen   = 1'b1;
            eth_waddr = {12'h000, offs};
            eth_wdata = data;
        end
        else
        begin
            fw_wen   = 1'b1;
            fw_waddr = {12'h000, offs};
            fw_wdata = data;
        end
        tick(1);
        fw_wen  = 1'b0;
        eth_wen = 1'b0;
    endtask

    task automatic check_read(input bit use_eth, input reg_addr_t a, input string name);
        if (use_eth)
            eth_raddr = a;
        else
            fw_raddr = a;
        ext_rdata = $urandom;
        step_check(name, SEL_RDATA, ref_read(a, ext_rdata));
    endtask

    task automatic watch_timeout();
        for (int i = 0; i < m_period * `WDOG_PRESCALE; i++)
            step_check("wdog window", SEL_TMO, 0);
        step_check("wdog expiry", SEL_TMO, 1);
        m_timeout = 1'b1;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial
    begin
        void'($urandom(1988));
        {fw_req_read, fw_req_write, fw_wen, fw_blk_wen, fw_blk_wstart} = '0;
        {eth_req_read, eth_req_write, eth_wen, eth_blk_wen, eth_blk_wstart} = '0;
        {fw_raddr, fw_waddr, eth_raddr, eth_waddr} = '0;
        {fw_wdata, eth_wdata, ext_rdata} = '0;
        {ext_rwait, wdog_clear} = '0;
        board_id  = 4'($urandom);
        m_scratch = '0;
        m_period  = '0;
        m_timeout = 1'b0;
        reset     = 1'b1;
        tick(3);
        reset = 1'b0;

        // reset state
        step_check("reset grants", SEL_GRANT, 4'b1010);
        step_check("reset lreq", SEL_LREQ, 0);
        step_check("reset timeout", SEL_TMO, 0);
        check_read(0, {12'h000, `REG_SCRATCH}, "reset scratch");

        // arbitration, fw wins while both ask
        set_requests(1, 1);
        step_check("both request", SEL_GRANT, {2{ref_grants(1, 1)}});
        {fw_req_read, fw_req_write} = 2'b00;
        step_check("grant hold", SEL_GRANT, {2{ref_grants(1, 1)}});
        step_check("grant to eth", SEL_GRANT, {2{ref_grants(0, 1)}});
        check_read(1, {`ADDR_EXT, 12'($urandom)}, "eth ext read");
        step_check("read mux eth", SEL_RADDR, {16'd0, eth_raddr});
        fw_waddr       = 16'h0111;
        eth_waddr      = {`ADDR_EXT, 12'($urandom)};   // outside the board registers
        eth_wdata      = $urandom;
        fw_wdata       = ~eth_wdata;
        eth_wen        = 1'b1;
        eth_blk_wen    = 1'b1;
        eth_blk_wstart = 1'b1;
        step_check("write mux", SEL_WADDR, {16'd0, eth_waddr});
        step_check("write data mux", SEL_WDATA, eth_wdata);
        step_check("write strobe mux", SEL_WCTRL, 3'b111);
        set_requests(1, 1);                             // back to fw
        step_check("read mux fw", SEL_RADDR, {16'd0, fw_raddr});
        step_check("write data mux fw", SEL_WDATA, fw_wdata);
        step_check("write strobe mux fw", SEL_WCTRL, 3'b000);
        {eth_wen, eth_blk_wen, eth_blk_wstart} = 3'b000;

        // register access from each host
        for (int h = 0; h < 2; h++)
        begin
            set_requests(h == 0, h == 1);
            for (int n = 0; n < 3; n++)
            begin
                d = $urandom;
                write_reg(h, `REG_SCRATCH, d);
                m_scratch = d;
                check_read(h, {12'h000, `REG_SCRATCH}, "scratch read");
            end
            check_read(h, {12'h000, `REG_VERSION}, "version read");
            check_read(h, {12'h000, `REG_STATUS}, "status read");
            check_read(h, {`ADDR_EXT, 12'($urandom)}, "ext space read");
        end
        set_requests(1, 0);

        // read valid
        fw_raddr = 16'h0004;
        step_check("rvalid no wait", SEL_RVALID, 1);
        ext_rwait = 1'b1;
        fw_raddr  = 16'h0005;
        step_check("rvalid new addr", SEL_RVALID, 0);
        step_check("rvalid held addr", SEL_RVALID, 1);
        ext_rwait = 1'b0;

        // phy request, bit 12 clear then set
        for (int r = 0; r < 2; r++)
        begin
            d = {19'($urandom), r[0], 12'($urandom)};
            frame_exp = ref_frame(d);
            write_reg(0, `REG_PHYCTRL, d);
            for (int i = 15; i >= 0; i--)
            begin
                if (i == 10)
                begin
                    fw_wen   = 1'b1;        // trigger while shifting
                    fw_waddr = {12'h000, `REG_PHYCTRL};
                    fw_wdata = ~d;
                end
                if (i == 9)
                    fw_wen = 1'b0;
                step_check("lreq bit", SEL_LREQ, {31'd0, frame_exp[i]});
            end
            repeat (3)
                step_check("lreq stop/idle", SEL_LREQ, 0);
        end

        // --------------------------------------------------
        // watchdog
        // --------------------------------------------------
        write_reg(0, `REG_WDOG, 32'd3);
        m_period = 16'd3;
        watch_timeout();
        step_check("wdog led/status", SEL_WDSTAT, {28'd0, 1'b1, 3'd1});
        check_read(0, {12'h000, `REG_STATUS}, "status timeout");
        wdog_clear = 1'b1;
        tick(1);
        wdog_clear = 1'b0;
        m_timeout  = 1'b0;
        step_check("wdog_clear", SEL_TMO, 0);
        write_reg(0, `REG_SCRATCH, 32'h5a5a_0000);    // restarts the counter
        m_scratch = 32'h5a5a_0000;
        watch_timeout();
        write_reg(0, `REG_WDOG, 32'd0);
        m_period  = '0;
        m_timeout = 1'b0;
        step_check("wdog write clear", SEL_TMO, 0);
        step_check("wdog disabled", SEL_WDSTAT, 0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
hw/bus_pkg.sv
hw/bus_arbiter.sv
hw/read_data_router.sv
hw/board_regs.sv
hw/phy_request.sv
hw/board_bus_core.sv
dv/board_bus_core_assert.sv
dv/board_bus_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= board_bus_core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
